/* Makefile */
SOURCES = tb.f hdl/uart_params.svh hdl/uartPkg.sv hdl/uartTx.sv hdl/uartRx.sv \
	hdl/uartRegs.sv hdl/uart.sv sim/uartTests.sv

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
obj_dir/VuartTests: $(SOURCES)
	verilator --binary --timing --assert --top-module uartTests -f tb.f -o VuartTests

# Exit status of the simulator is the regression result
run: obj_dir/VuartTests
	./obj_dir/VuartTests

clean:
	rm -rf obj_dir

/* hdl/uart.sv */
`default_nettype none
`include "uart_params.svh"

module uart
	import uartPkg::*;
(
	input wire CLK,
	input wire reset,
	input wire [1:0] addr,
	input wire rd,
	input wire wr,
	input wire [`UART_WORD_WIDTH-1:0] din,
	output logic [`UART_WORD_WIDTH-1:0] dout,
	output logic uartInt,
	input wire rxd,
	output logic txd
);

	txRequest_t txReq;
	txStatus_t txStat;
	rxChar_t rxChar;
	logic [`UART_WORD_WIDTH-1:0] rxDivider;

	// CPU side registers and flags
	uartRegs regs (
		.CLK(CLK),
		.reset(reset),
		.addr(addr),
		.rd(rd),
		.wr(wr),
		.din(din),
		.dout(dout),
		.uartInt(uartInt),
		.txReq(txReq),
		.txStat(txStat),
		.rxDivider(rxDivider),
		.rxIn(rxChar)
	);

	// Serial line out
	uartTx tx (
		.CLK(CLK),
		.reset(reset),
		.req(txReq),
		.stat(txStat),
		.txd(txd)
	);

	// Serial line in
	uartRx rx (
		.CLK(CLK),
		.reset(reset),
		.divider(rxDivider),
		.rxd(rxd),
		.char(rxChar)
	);

endmodule

`default_nettype wire

/* hdl/uartPkg.sv */
`default_nettype none
`include "uart_params.svh"

package uartPkg;

	// Character view of a bus word
	typedef struct packed {
		logic [`UART_WORD_WIDTH-`UART_CHAR_WIDTH-1:0] reserved;
		logic [`UART_CHAR_WIDTH-1:0] character;
	} busChar_t;

	// One bus word, decoded by register address
	typedef union packed {
		busChar_t charView;
		logic [`UART_WORD_WIDTH-1:0] divider;
	} busWord_u;

	// Register block to transmitter
	typedef struct packed {
		logic start;
		logic [`UART_CHAR_WIDTH-1:0] character;
		logic [`UART_WORD_WIDTH-1:0] divider;
	} txRequest_t;

	// Transmitter back to register block
	typedef struct packed {
		logic active;
		logic done;
	} txStatus_t;

	// Receiver to register block, valid lasts one cycle
	typedef struct packed {
		logic valid;
		logic [`UART_CHAR_WIDTH-1:0] character;
	} rxChar_t;

endpackage

`default_nettype wire

/* hdl/uartRegs.sv */
`default_nettype none
`include "uart_params.svh"

module uartRegs
	import uartPkg::*;
(
	input wire CLK,
	input wire reset,
	input wire [1:0] addr,
	input wire rd,
	input wire wr,
	input wire busWord_u din,
	output logic [`UART_WORD_WIDTH-1:0] dout,
	output logic uartInt,
	output txRequest_t txReq,
	input wire txStatus_t txStat,
	output logic [`UART_WORD_WIDTH-1:0] rxDivider,
	input wire rxChar_t rxIn
);

	logic [`UART_WORD_WIDTH-1:0] txDivider;
	logic [`UART_CHAR_WIDTH-1:0] rxBuffer;
	logic txActive;
	logic txComplete;
	logic dataAvailable;
	logic rxInterrupt;
	logic txInterrupt;
	logic overrun;
	logic ieRx;
	logic ieTx;
	logic [`UART_WORD_WIDTH-1:0] statusWord;
	logic [`UART_WORD_WIDTH-1:0] readWord;

	// Strobe decode
	logic wrStatus, wrData, wrTxDiv, wrRxDiv;
	logic rdStatus, rdData;

	assign wrStatus = wr && addr == `UART_REG_STATUS;
	assign wrData = wr && addr == `UART_REG_DATA;
	assign wrTxDiv = wr && addr == `UART_REG_TXDIV;
	assign wrRxDiv = wr && addr == `UART_REG_RXDIV;
	assign rdStatus = rd && addr == `UART_REG_STATUS;
	assign rdData = rd && addr == `UART_REG_DATA;

	// Short periods would break the half-bit wait in the receiver
	function automatic logic [`UART_WORD_WIDTH-1:0] clampDivider(
		input logic [`UART_WORD_WIDTH-1:0] value
	);
		return (value < `UART_MIN_DIVIDER) ? `UART_MIN_DIVIDER : value;
	endfunction

	// A data write while sending is dropped
	assign txReq = '{
		start: wrData && !txActive,
		character: din.charView.character,
		divider: txDivider
	};

	always_ff @(posedge CLK) begin
		if (reset) begin
			txDivider <= `UART_RESET_DIVIDER;
			rxDivider <= `UART_RESET_DIVIDER;
			txActive <= 1'b0;
			txComplete <= 1'b1;
			dataAvailable <= 1'b0;
			rxInterrupt <= 1'b0;
			txInterrupt <= 1'b0;
			overrun <= 1'b0;
			ieRx <= 1'b0;
			ieTx <= 1'b0;
			uartInt <= 1'b0;
		end else begin
			if (wrTxDiv)
				txDivider <= clampDivider(din.divider);
			if (wrRxDiv)
				rxDivider <= clampDivider(din.divider);
			if (wrStatus) begin
				ieRx <= |(din & `UART_IE_RX);
				ieTx <= |(din & `UART_IE_TX);
			end
			// Read side effects first so new events win
			if (rdStatus)
				txInterrupt <= 1'b0;
			if (rdData) begin
				dataAvailable <= 1'b0;
				rxInterrupt <= 1'b0;
				overrun <= 1'b0;
			end
			if (txReq.start) begin
				txActive <= 1'b1;
				txComplete <= 1'b0;
			end else if (txStat.done) begin
				txActive <= 1'b0;
				txComplete <= 1'b1;
				txInterrupt <= 1'b1;
			end
			// Unread character is overwritten
			if (rxIn.valid) begin
				dataAvailable <= 1'b1;
				rxInterrupt <= 1'b1;
				if (dataAvailable && !rdData)
					overrun <= 1'b1;
			end
			uartInt <= (rxInterrupt && ieRx) || (txInterrupt && ieTx);
		end
	end

	always_ff @(posedge CLK) begin
		if (rxIn.valid)
			rxBuffer <= rxIn.character;
	end

	always_comb begin
		statusWord = '0;
		if (txActive) statusWord |= `UART_STATUS_TX_ACTIVE;
		if (txComplete) statusWord |= `UART_STATUS_TX_COMPLETE;
		if (dataAvailable) statusWord |= `UART_STATUS_DATA_AVAILABLE;
		if (rxInterrupt) statusWord |= `UART_STATUS_RX_INTERRUPT;
		if (txInterrupt) statusWord |= `UART_STATUS_TX_INTERRUPT;
		if (overrun) statusWord |= `UART_STATUS_OVERRUN;
	end

	// Read mux, zero when the bus is not reading
	always_comb begin
		readWord = '0;
		case (addr)
			`UART_REG_STATUS: readWord = statusWord;
			`UART_REG_DATA: readWord = {{(`UART_WORD_WIDTH-`UART_CHAR_WIDTH){1'b0}}, rxBuffer};
			`UART_REG_TXDIV: readWord = txDivider;
			`UART_REG_RXDIV: readWord = rxDivider;
		endcase
	end

	assign dout = rd ? readWord : '0;

	assert property (@(posedge CLK) disable iff (reset) !(rd && wr));
	// Transmitter must be idle whenever a start goes out
	assert property (@(posedge CLK) disable iff (reset)
		txReq.start |-> !txStat.active);

endmodule

`default_nettype wire

/* hdl/uartRx.sv */
`default_nettype none
`include "uart_params.svh"

module uartRx
	import uartPkg::*;
(
	input wire CLK,
	input wire reset,
	input wire [`UART_WORD_WIDTH-1:0] divider,
	input wire rxd,
	output rxChar_t char
);

	typedef enum logic [1:0] {
		idle,
		startBit,
		dataBits,
		stopBit
	} rxState_t;

	rxState_t state;
	logic [1:0] rxSync;
	logic rxPrev;
	logic [`UART_WORD_WIDTH-1:0] cycleCount;
	logic [2:0] bitIndex;
	logic [`UART_CHAR_WIDTH-1:0] shifter;
	logic [`UART_CHAR_WIDTH-1:0] received;
	logic valid;
	logic rxLine;
	logic fallingEdge;

	// Two flops against metastability, sync output is the line
	always_ff @(posedge CLK) begin
		if (reset) begin
			rxSync <= 2'b11;
			rxPrev <= 1'b1;
		end else begin
			rxSync <= {rxSync[0], rxd};
			rxPrev <= rxSync[1];
		end
	end

	assign rxLine = rxSync[1];
	assign fallingEdge = rxPrev && !rxLine;

	always_ff @(posedge CLK) begin
		if (reset) begin
			state <= idle;
			cycleCount <= '0;
			bitIndex <= '0;
			valid <= 1'b0;
		end else begin
			valid <= 1'b0;
			case (state)
				idle: begin
					if (fallingEdge) begin
						// Wait half a bit to land mid start bit
						cycleCount <= {1'b0, divider[`UART_WORD_WIDTH-1:1]} - 16'd1;
						state <= startBit;
					end
				end
				startBit: begin
					if (cycleCount != '0) begin
						cycleCount <= cycleCount - 16'd1;
					end else if (!rxLine) begin
						cycleCount <= divider - 16'd1;
						bitIndex <= '0;
						state <= dataBits;
					end else begin
						// Glitch, not a real start bit
						state <= idle;
					end
				end
				dataBits: begin
					if (cycleCount != '0) begin
						cycleCount <= cycleCount - 16'd1;
					end else begin
						// LSB first, so shift in from the top
						shifter <= {rxLine, shifter[`UART_CHAR_WIDTH-1:1]};
						cycleCount <= divider - 16'd1;
						bitIndex <= bitIndex + 3'd1;
						if (bitIndex == 3'd7)
							state <= stopBit;
					end
				end
				stopBit: begin
					if (cycleCount != '0) begin
						cycleCount <= cycleCount - 16'd1;
					end else begin
						// Bad stop bit drops the character
						if (rxLine) begin
							received <= shifter;
							valid <= 1'b1;
						end
						state <= idle;
					end
				end
				default: state <= idle;
			endcase
		end
	end

	assign char = '{valid: valid, character: received};

	// Frames are at least ten bits apart
	assert property (@(posedge CLK) disable iff (reset)
		char.valid |=> !char.valid);

endmodule

`default_nettype wire

/* hdl/uartTx.sv */
`default_nettype none
`include "uart_params.svh"

module uartTx
	import uartPkg::*;
(
	input wire CLK,
	input wire reset,
	input wire txRequest_t req,
	output txStatus_t stat,
	output logic txd
);

	// Start bit, eight data bits, stop bit
	localparam int frameBits = 10;

	logic [frameBits-1:0] frame;
	logic [`UART_WORD_WIDTH-1:0] reload;
	logic [`UART_WORD_WIDTH-1:0] cycleCount;
	logic [3:0] bitsLeft;
	logic active;
	logic done;

	always_ff @(posedge CLK) begin
		if (reset) begin
			// Frame of ones keeps the line idle high
			frame <= '1;
			cycleCount <= '0;
			bitsLeft <= '0;
			active <= 1'b0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			if (!active) begin
				if (req.start) begin
					// Stop bit on top, start bit goes out first
					frame <= {1'b1, req.character, 1'b0};
					reload <= req.divider - 16'd1;
					cycleCount <= req.divider - 16'd1;
					bitsLeft <= 4'(frameBits - 1);
					active <= 1'b1;
				end
			end else if (cycleCount != '0) begin
				cycleCount <= cycleCount - 16'd1;
			end else if (bitsLeft == '0) begin
				// Stop bit finished
				active <= 1'b0;
				done <= 1'b1;
			end else begin
				// Next bit, shifting in idle ones behind it
				frame <= {1'b1, frame[frameBits-1:1]};
				bitsLeft <= bitsLeft - 4'd1;
				cycleCount <= reload;
			end
		end
	end

	assign txd = frame[0];
	assign stat = '{active: active, done: done};

	// Done is a single pulse right after the frame
	assert property (@(posedge CLK) disable iff (reset)
		stat.done |-> $past(stat.active) && !stat.active);
	assert property (@(posedge CLK) disable iff (reset)
		stat.done |=> !stat.done);

endmodule

`default_nettype wire

/* hdl/uart_params.svh */
`ifndef UART_PARAMS_SVH
`define UART_PARAMS_SVH

// Register map, one word per address
`define UART_REG_STATUS 2'd0
`define UART_REG_DATA 2'd1
`define UART_REG_TXDIV 2'd2
`define UART_REG_RXDIV 2'd3

// Status word bits as seen on a read
`define UART_STATUS_TX_ACTIVE 16'h0001
`define UART_STATUS_TX_COMPLETE 16'h0002
`define UART_STATUS_DATA_AVAILABLE 16'h0004
`define UART_STATUS_RX_INTERRUPT 16'h0008
`define UART_STATUS_TX_INTERRUPT 16'h0010
`define UART_STATUS_OVERRUN 16'h0020

// Interrupt enables carried by a status write
`define UART_IE_RX 16'h0001
`define UART_IE_TX 16'h0002

// Bus word and character widths
`define UART_WORD_WIDTH 16
`define UART_CHAR_WIDTH 8

// Bit period in system clocks
`define UART_RESET_DIVIDER 16'd16
`define UART_MIN_DIVIDER 16'd2

`endif

/* sim/uartTests.sv */
`default_nettype none
`include "uart_params.svh"

module uartTests;

	// Frames at divider 4 plus eight random frames at the largest divider
	localparam int frameCycles = 4 * 10 * 4 + 8 * 10 * 9;
	localparam int cycleLimit = frameCycles + 200;

	logic CLK;
	logic reset;
	logic [1:0] addr;
	logic rd;
	logic wr;
	logic [`UART_WORD_WIDTH-1:0] din;
	wire [`UART_WORD_WIDTH-1:0] dout;
	wire uartInt;
	wire txd;
	integer seed;
	int cycles;

	// Serial loopback with the line out feeding the line in
	uart DUT (
		.CLK(CLK),
		.reset(reset),
		.addr(addr),
		.rd(rd),
		.wr(wr),
		.din(din),
		.dout(dout),
		.uartInt(uartInt),
		.rxd(txd),
		.txd(txd)
	);

	always #2 CLK = ~CLK;

	always @(posedge CLK) begin
		cycles = cycles + 1;
		if (cycles >= cycleLimit) begin
			$display("Timeout: the tests did not finish within %0d cycles", cycleLimit);
			$display("Regression failed");
			$fatal(1, "Run stopped at the cycle limit");
		end
	end

	task automatic expectWord(input string name, input logic [15:0] expected,
		input logic [15:0] actual);
		assert (actual === expected) else begin
			$display("CHECK FAILED at %0t: %s expected %h got %h", $time, name, expected, actual);
			$display("Regression failed");
			$fatal(1, "Stopping at the first mismatch");
		end
	endtask

	task automatic expectLevel(input string name, input logic expected, input logic actual);
		assert (actual === expected) else begin
			$display("CHECK FAILED at %0t: %s expected %b got %b", $time, name, expected, actual);
			$display("Regression failed");
			$fatal(1, "Stopping at the first mismatch");
		end
	endtask

	// Bus tasks start and end on a falling edge and take one cycle
	task automatic busWrite(input logic [1:0] where, input logic [15:0] word);
		addr = where;
		din = word;
		wr = 1'b1;
		@(negedge CLK);
		wr = 1'b0;
	endtask

	task automatic busRead(input logic [1:0] where, output logic [15:0] word);
		addr = where;
		rd = 1'b1;
		// Mid cycle well clear of the rising edge
		#1;
		word = dout;
		@(negedge CLK);
		rd = 1'b0;
	endtask

	task automatic readCheck(input logic [1:0] where, input string name,
		input logic [15:0] expected);
		logic [15:0] value;
		busRead(where, value);
		expectWord(name, expected, value);
	endtask

	task automatic waitCycles(input int count);
		repeat (count) @(negedge CLK);
	endtask

	// Polls status until every bit of the mask is set
	task automatic waitStatus(input logic [15:0] mask);
		logic [15:0] value;
		value = '0;
		while ((value & mask) != mask)
			busRead(`UART_REG_STATUS, value);
	endtask

	task automatic resetState();
		// Bus is idle so the read port stays at zero
		expectWord("dout", 16'h0000, dout);
		expectLevel("txd", 1'b1, txd);
		readCheck(`UART_REG_STATUS, "status", `UART_STATUS_TX_COMPLETE);
		expectLevel("uartInt", 1'b0, uartInt);
	endtask

	task automatic transmitStatus();
		busWrite(`UART_REG_TXDIV, 16'd4);
		busWrite(`UART_REG_RXDIV, 16'd4);
		busWrite(`UART_REG_DATA, 16'habcd);
		// Start bit is on the line from the write edge
		expectLevel("txd", 1'b0, txd);
		readCheck(`UART_REG_STATUS, "status", `UART_STATUS_TX_ACTIVE);
	endtask

	task automatic loopbackReceive();
		waitCycles(10 * 4 + 12);
		readCheck(`UART_REG_STATUS, "status", `UART_STATUS_TX_COMPLETE |
			`UART_STATUS_TX_INTERRUPT | `UART_STATUS_DATA_AVAILABLE | `UART_STATUS_RX_INTERRUPT);
		readCheck(`UART_REG_DATA, "data", 16'h00cd);
		// Status read above already took TX_INTERRUPT away
		readCheck(`UART_REG_STATUS, "status", `UART_STATUS_TX_COMPLETE);
	endtask

	task automatic interruptLevel();
		busWrite(`UART_REG_STATUS, `UART_IE_RX | `UART_IE_TX);
		busWrite(`UART_REG_DATA, 16'h0042);
		// Nothing pending while the frame is still going out
		expectLevel("uartInt", 1'b0, uartInt);
		while (uartInt !== 1'b1)
			@(negedge CLK);
		waitStatus(`UART_STATUS_TX_COMPLETE);
		// TX cleared by the poll while RX stays pending
		waitCycles(2);
		expectLevel("uartInt", 1'b1, uartInt);
		readCheck(`UART_REG_DATA, "data", 16'h0042);
		waitCycles(2);
		expectLevel("uartInt", 1'b0, uartInt);
		busWrite(`UART_REG_STATUS, 16'h0000);
	endtask

	task automatic overrunBuffer();
		busWrite(`UART_REG_DATA, 16'h0031);
		waitStatus(`UART_STATUS_TX_COMPLETE | `UART_STATUS_DATA_AVAILABLE);
		busWrite(`UART_REG_DATA, 16'h0032);
		waitStatus(`UART_STATUS_TX_COMPLETE | `UART_STATUS_OVERRUN);
		readCheck(`UART_REG_STATUS, "status", `UART_STATUS_TX_COMPLETE |
			`UART_STATUS_DATA_AVAILABLE | `UART_STATUS_RX_INTERRUPT | `UART_STATUS_OVERRUN);
		readCheck(`UART_REG_DATA, "data", 16'h0032);
		readCheck(`UART_REG_STATUS, "status", `UART_STATUS_TX_COMPLETE);
	endtask

	task automatic randomLoopback();
		logic [15:0] word;
		logic [15:0] divider;
		for (int i = 0; i < 8; i++) begin
			// High byte is reserved and must not reach the line
			word = 16'($random(seed));
			divider = 16'(2 + {$random(seed)} % 8);
			busWrite(`UART_REG_TXDIV, divider);
			busWrite(`UART_REG_RXDIV, divider);
			busWrite(`UART_REG_DATA, word);
			waitStatus(`UART_STATUS_TX_COMPLETE | `UART_STATUS_DATA_AVAILABLE);
			readCheck(`UART_REG_DATA, "data", word & 16'h00ff);
		end
	endtask

	initial begin
		CLK = 1'b0;
		reset = 1'b1;
		addr = 2'd0;
		rd = 1'b0;
		wr = 1'b0;
		din = '0;
		seed = 71;
		cycles = 0;
		repeat (5) @(posedge CLK);
		@(negedge CLK);
		reset = 1'b0;
		resetState();
		transmitStatus();
		loopbackReceive();
		interruptLevel();
		overrunBuffer();
		randomLoopback();
		$display("Regression passed");
		$finish;
	end

endmodule

`default_nettype wire

/* tb.f */
+incdir+hdl
hdl/uartPkg.sv
hdl/uartTx.sv
hdl/uartRx.sv
hdl/uartRegs.sv
hdl/uart.sv
sim/uartTests.sv
